// ==== project.f ====
+incdir+rtl
rtl/ll_pkg.sv
rtl/link_if.sv
rtl/online_delay.sv
rtl/ll_transmit.sv
rtl/ll_receive.sv
rtl/phy_lane.sv
rtl/axi_lite_rd_master_top.sv
tb/tb_axi_lite_rd_master.sv

// ==== rtl/axi_lite_rd_master_top.sv ====
// AXI-lite read master over one 40-bit lane; instantiate as the DUT with plain AXI ports
`timescale 1ns/1ps
`default_nettype none
`include "ll_defines.svh"

module axi_lite_rd_master_top (
  input  logic                  clk_wr,
  input  logic                  arst_n,

  // Link control
  input  logic                  tx_online,
  input  logic                  rx_online,
  input  logic [`LL_CRED_W-1:0] init_ar_credit,
  input  logic [15:0]           delay_x_value,
  input  logic [15:0]           delay_y_value,

  // AR channel
  input  logic [`LL_ADDR_W-1:0] user_araddr,
  input  logic                  user_arvalid,
  output logic                  user_arready,

  // R channel
  output logic [`LL_DATA_W-1:0] user_rdata,
  output logic [`LL_RESP_W-1:0] user_rresp,
  output logic                  user_rvalid,
  input  logic                  user_rready,

  // PHY lane
  output logic [`LL_LANE_W-1:0] tx_phy0,
  input  logic [`LL_LANE_W-1:0] rx_phy0
);

  logic tx_online_delay;
  logic rx_online_delay;

  link_if link ();

  ////////////////////////////////////////
  // Online sequencing
  online_delay online_delay_i (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay)
  );

  ////////////////////////////////////////
  // Channel engines
  ll_transmit ll_transmit_iar (
    .clk_wr      (clk_wr),
    .arst_n      (arst_n),
    .tx_online   (tx_online_delay),
    .init_credit (init_ar_credit),
    .araddr      (user_araddr),
    .arvalid     (user_arvalid),
    .arready     (user_arready),
    .link        (link.xmit)
  );

  ll_receive ll_receive_ir (
    .clk_wr    (clk_wr),
    .arst_n    (arst_n),
    .rx_online (rx_online_delay),
    .rdata     (user_rdata),
    .rresp     (user_rresp),
    .rvalid    (user_rvalid),
    .rready    (user_rready),
    .link      (link.recv)
  );

  ////////////////////////////////////////
  // Lane
  phy_lane phy_lane_i (
    .clk_wr  (clk_wr),
    .arst_n  (arst_n),
    .tx_phy0 (tx_phy0),
    .rx_phy0 (rx_phy0),
    .link    (link.lane)
  );

endmodule

`default_nettype wire

// ==== rtl/link_if.sv ====
// Strobe bundle joining the AR and R channel engines to the PHY lane packer
`timescale 1ns/1ps
`default_nettype none
`include "ll_defines.svh"

interface link_if;

  // AR direction, tx_cred is the AR credit coming back
  logic                  tx_push;
  logic [`LL_ADDR_W-1:0] tx_data;
  logic                  tx_cred;

  // R direction, rx_cred is the R credit going out
  logic                  rx_push;
  logic [`LL_R_W-1:0]    rx_data;
  logic                  rx_cred;

  modport xmit (output tx_push, output tx_data, input tx_cred);

  modport recv (input rx_push, input rx_data, output rx_cred);

  modport lane (input tx_push, input tx_data, input rx_cred,
                output tx_cred, output rx_push, output rx_data);

endinterface

`default_nettype wire

// ==== rtl/ll_defines.svh ====
// Widths, FIFO depth and lane bit map of the read link; include in every RTL and TB file
`ifndef LL_DEFINES_SVH
`define LL_DEFINES_SVH

// AXI-lite read fields
`define LL_ADDR_W 32
`define LL_DATA_W 32
`define LL_RESP_W 2
// R flit carries the response above the data
`define LL_R_W 34

// PHY lane word
`define LL_LANE_W 40

// Buffering and credits
`define LL_RX_DEPTH 8
`define LL_RX_PTR_W 3
`define LL_CRED_W 8

// tx lane map, all other bits zero
`define LL_TX_PUSH_BIT 0
`define LL_TX_DATA_LSB 1
`define LL_TX_CRED_BIT 33

// rx lane map
`define LL_RX_PUSH_BIT 0
`define LL_RX_DATA_LSB 1
`define LL_RX_CRED_BIT 35

`endif

// ==== rtl/ll_pkg.sv ====
// Lane word pack and split helpers plus the credit check, imported by the link modules
`default_nettype none
`include "ll_defines.svh"

package ll_pkg;

  // Address field only carries data alongside the pushbit
  function automatic logic [`LL_LANE_W-1:0] tx_lane_pack(
    input logic                  push,
    input logic [`LL_ADDR_W-1:0] addr,
    input logic                  cred
  );
    logic [`LL_LANE_W-1:0] lane;
    lane = '0;
    lane[`LL_TX_PUSH_BIT] = push;
    lane[`LL_TX_DATA_LSB +: `LL_ADDR_W] = push ? addr : '0;
    lane[`LL_TX_CRED_BIT] = cred;
    return lane;
  endfunction

  function automatic void rx_lane_split(
    input  logic [`LL_LANE_W-1:0] lane,
    output logic                  push,
    output logic [`LL_R_W-1:0]    flit,
    output logic                  cred
  );
    push = lane[`LL_RX_PUSH_BIT];
    flit = lane[`LL_RX_DATA_LSB +: `LL_R_W];
    cred = lane[`LL_RX_CRED_BIT];
  endfunction

  function automatic logic credit_avail(input logic [`LL_CRED_W-1:0] cnt);
    return (cnt != '0);
  endfunction

endpackage

`default_nettype wire

// ==== rtl/ll_receive.sv ====
// R channel engine; buffers incoming flits in a FIFO and returns one credit per pop
`timescale 1ns/1ps
`default_nettype none
`include "ll_defines.svh"

module ll_receive (
  input  logic                  clk_wr,
  input  logic                  arst_n,
  input  logic                  rx_online,
  output logic [`LL_DATA_W-1:0] rdata,
  output logic [`LL_RESP_W-1:0] rresp,
  output logic                  rvalid,
  input  logic                  rready,
  link_if.recv                  link
);

  logic [`LL_R_W-1:0]      mem [`LL_RX_DEPTH];
  logic [`LL_RX_PTR_W-1:0] wr_ptr;
  logic [`LL_RX_PTR_W-1:0] rd_ptr;
  logic [`LL_RX_PTR_W:0]   count;
  logic                    push;
  logic                    pop;
  logic                    pop_q;
  logic                    cred_q;

  // Flits arriving while offline are dropped
  assign push = rx_online && link.rx_push;
  assign pop  = rvalid && rready;

  assign rvalid         = (count != '0);
  assign {rresp, rdata} = mem[rd_ptr];

  ////////////////////////////////////////
  // FIFO storage and pointers
  always_ff @(posedge clk_wr) begin
    if (push) begin
      mem[wr_ptr] <= link.rx_data;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////////////////////////
  // Credit return, two stages behind the pop
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      pop_q  <= 1'b0;
      cred_q <= 1'b0;
    end else begin
      pop_q  <= pop;
      cred_q <= pop_q;
    end
  end

  assign link.rx_cred = cred_q;

  // Far side must stay within its R credits
  a_no_overflow: assert property (@(posedge clk_wr) disable iff (!arst_n)
    push |-> (count != `LL_RX_DEPTH));

endmodule

`default_nettype wire

// ==== rtl/ll_transmit.sv ====
// AR channel engine; one-entry address buffer sent over the link against a credit counter
`timescale 1ns/1ps
`default_nettype none
`include "ll_defines.svh"

module ll_transmit
  import ll_pkg::*;
(
  input  logic                  clk_wr,
  input  logic                  arst_n,
  input  logic                  tx_online,
  input  logic [`LL_CRED_W-1:0] init_credit,
  input  logic [`LL_ADDR_W-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,
  link_if.xmit                  link
);

  logic                  buf_full;
  logic [`LL_ADDR_W-1:0] buf_addr;
  logic [`LL_CRED_W-1:0] cred_cnt;
  logic                  send;
  logic                  push_q;
  logic [`LL_ADDR_W-1:0] data_q;

  assign arready = !buf_full;
  assign send    = buf_full && tx_online && credit_avail(cred_cnt);

  ////////////////////////////////////////
  // Entry buffer
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      buf_full <= 1'b0;
    end else if (arvalid && arready) begin
      buf_full <= 1'b1;
    end else if (send) begin
      buf_full <= 1'b0;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (arvalid && arready) begin
      buf_addr <= araddr;
    end
  end

  // Link side, one strobe per address
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      push_q <= 1'b0;
    end else begin
      push_q <= send;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (send) begin
      data_q <= buf_addr;
    end
  end

  assign link.tx_push = push_q;
  assign link.tx_data = data_q;

  ////////////////////////////////////////
  // Credit counter, reloads while offline
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      cred_cnt <= '0;
    end else if (!tx_online) begin
      cred_cnt <= init_credit;
    end else if (push_q && !link.tx_cred) begin
      cred_cnt <= cred_cnt - 1'b1;
    end else if (link.tx_cred && !push_q) begin
      cred_cnt <= cred_cnt + 1'b1;
    end
  end

  // Far side returns no more than it was granted
  a_cred_no_wrap: assert property (@(posedge clk_wr) disable iff (!arst_n)
    (tx_online && link.tx_cred && !push_q) |-> (cred_cnt != '1));

  a_cred_no_underflow: assert property (@(posedge clk_wr) disable iff (!arst_n)
    (tx_online && push_q && !link.tx_cred) |-> (cred_cnt != '0));

endmodule

`default_nettype wire

// ==== rtl/online_delay.sv ====
// Holds off tx_online and rx_online until each has been high for its programmed cycle count
`timescale 1ns/1ps
`default_nettype none

module online_delay (
  input  logic        clk_wr,
  input  logic        arst_n,
  input  logic        tx_online,
  input  logic        rx_online,
  input  logic [15:0] delay_x_value,
  input  logic [15:0] delay_y_value,
  output logic        tx_online_delay,
  output logic        rx_online_delay
);

  // Slot 0 is tx, slot 1 is rx
  logic [1:0]  online_in;
  logic [1:0]  online_out;
  logic [15:0] delay_val [2];

  assign online_in    = {rx_online, tx_online};
  assign delay_val[0] = delay_y_value;
  assign delay_val[1] = delay_x_value;

  for (genvar i = 0; i < 2; i++) begin : g_dly
    logic [15:0] cnt;
    logic        out_q;

    // Restart while low, saturate at the programmed value
    always_ff @(posedge clk_wr or negedge arst_n) begin
      if (!arst_n) begin
        cnt   <= '0;
        out_q <= 1'b0;
      end else if (!online_in[i]) begin
        cnt   <= '0;
        out_q <= 1'b0;
      end else begin
        if (cnt < delay_val[i]) begin
          cnt <= cnt + 16'd1;
        end
        out_q <= (cnt >= delay_val[i]);
      end
    end

    assign online_out[i] = out_q;
  end

  assign tx_online_delay = online_out[0];
  assign rx_online_delay = online_out[1];

endmodule

`default_nettype wire

// ==== rtl/phy_lane.sv ====
// Lane packer; registers the tx and rx PHY words and maps link strobes to lane bits
`timescale 1ns/1ps
`default_nettype none
`include "ll_defines.svh"

module phy_lane
  import ll_pkg::*;
(
  input  logic                  clk_wr,
  input  logic                  arst_n,
  output logic [`LL_LANE_W-1:0] tx_phy0,
  input  logic [`LL_LANE_W-1:0] rx_phy0,
  link_if.lane                  link
);

  logic [`LL_LANE_W-1:0] rx_lane_q;
  logic                  rx_push_w;
  logic [`LL_R_W-1:0]    rx_flit_w;
  logic                  tx_cred_w;

  ////////////////////////////////////////
  // tx direction
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_phy0 <= '0;
    end else begin
      tx_phy0 <= tx_lane_pack(link.tx_push, link.tx_data, link.rx_cred);
    end
  end

  ////////////////////////////////////////
  // rx direction
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_lane_q <= '0;
    end else begin
      rx_lane_q <= rx_phy0;
    end
  end

  // Pushbit, R flit and returned AR credit
  always_comb begin
    rx_lane_split(rx_lane_q, rx_push_w, rx_flit_w, tx_cred_w);
  end

  assign link.rx_push = rx_push_w;
  assign link.rx_data = rx_flit_w;
  assign link.tx_cred = tx_cred_w;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module tb_axi_lite_rd_master &&
./obj_dir/Vtb_axi_lite_rd_master | tee /dev/stderr | grep -q "^ALL CHECKS PASSED$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== tb/tb_axi_lite_rd_master.sv ====
// Self-checking testbench for the AXI-lite read master; run from the project root with project.f
`timescale 1ns/1ps
`default_nettype none
`include "ll_defines.svh"

module tb_axi_lite_rd_master;

  logic                  clk_wr;
  logic                  arst_n;
  logic                  tx_online;
  logic                  rx_online;
  logic [`LL_CRED_W-1:0] init_ar_credit;
  logic [15:0]           delay_x_value;
  logic [15:0]           delay_y_value;
  logic [`LL_ADDR_W-1:0] user_araddr;
  logic                  user_arvalid;
  logic                  user_arready;
  logic [`LL_DATA_W-1:0] user_rdata;
  logic [`LL_RESP_W-1:0] user_rresp;
  logic                  user_rvalid;
  logic                  user_rready;
  logic [`LL_LANE_W-1:0] tx_phy0;
  logic [`LL_LANE_W-1:0] rx_phy0;

  // Test data and scoreboard
  logic [`LL_ADDR_W-1:0] addr_q[$];
  logic [`LL_R_W-1:0]    flit_q[$];
  logic [`LL_CRED_W-1:0] ar_credit;
  logic [`LL_R_W-1:0]    exp_flit;
  logic [`LL_LANE_W-1:0] idle_word;
  logic [15:0]           lfsr_state;
  logic                  loaded;
  logic                  ar_done;
  int                    n_lines;
  int                    n_a;
  int                    n_r;
  int                    push_cnt;
  int                    rcred_cnt;
  int                    pop_cnt;
  int                    err_cnt;
  int                    chk_cnt;
  int                    test_start;
  int                    sent;
  int                    k;

  axi_lite_rd_master_top uut (
    .clk_wr         (clk_wr),
    .arst_n         (arst_n),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .init_ar_credit (init_ar_credit),
    .delay_x_value  (delay_x_value),
    .delay_y_value  (delay_y_value),
    .user_araddr    (user_araddr),
    .user_arvalid   (user_arvalid),
    .user_arready   (user_arready),
    .user_rdata     (user_rdata),
    .user_rresp     (user_rresp),
    .user_rvalid    (user_rvalid),
    .user_rready    (user_rready),
    .tx_phy0        (tx_phy0),
    .rx_phy0        (rx_phy0)
  );

  always #10 clk_wr = ~clk_wr;

  ////////////////////////////////////////
  // Stimulus helpers

  // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 stepped once per bit
  function automatic logic next_bit();
    lfsr_state = {lfsr_state[14:0],
                  lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
    return lfsr_state[0];
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(next_bit());
    end
    return v;
  endfunction

  // Expected tx lane word for one address
  function automatic logic [`LL_LANE_W-1:0] ar_word(input logic [`LL_ADDR_W-1:0] addr);
    logic [`LL_LANE_W-1:0] w;
    w = '0;
    w[`LL_TX_PUSH_BIT] = 1'b1;
    w[`LL_TX_DATA_LSB +: `LL_ADDR_W] = addr;
    return w;
  endfunction

  function automatic logic [`LL_LANE_W-1:0] r_word(input logic [`LL_R_W-1:0] flit);
    logic [`LL_LANE_W-1:0] w;
    w = '0;
    w[`LL_RX_PUSH_BIT] = 1'b1;
    w[`LL_RX_DATA_LSB +: `LL_R_W] = flit;
    return w;
  endfunction

  function automatic logic [`LL_LANE_W-1:0] ar_cred_word();
    logic [`LL_LANE_W-1:0] w;
    w = '0;
    w[`LL_RX_CRED_BIT] = 1'b1;
    return w;
  endfunction

  task check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    chk_cnt++;
    if (exp !== act) begin
      $display("FAIL %0t ns %s expected %h actual %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task end_test(input string name);
    if (err_cnt == test_start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_cnt - test_start);
    end
  endtask

  // One AR transfer with valid held until arready
  task send_addr(input logic [`LL_ADDR_W-1:0] addr);
    @(posedge clk_wr);
    user_araddr  <= addr;
    user_arvalid <= 1'b1;
    do begin
      @(negedge clk_wr);
    end while (!user_arready);
    @(posedge clk_wr);
    user_arvalid <= 1'b0;
  endtask

  // Lines starting with anything but A, R or C are skipped
  task read_testdata();
    int          fd;
    int          rc;
    string       line;
    logic [31:0] v0;
    logic [31:0] v1;
    fd = $fopen("tb/testdata_rd.txt", "r");
    if (fd == 0) begin
      $display("could not open tb/testdata_rd.txt");
      return;
    end
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      if (rc > 0 && line.len() > 1) begin
        if (line[0] == "A") begin
          rc = $sscanf(line, "A %h", v0);
          addr_q.push_back(v0);
          n_lines++;
        end else if (line[0] == "R") begin
          rc = $sscanf(line, "R %h %h", v1, v0);
          flit_q.push_back({v1[1:0], v0});
          n_lines++;
        end else if (line[0] == "C") begin
          rc = $sscanf(line, "C %h", v0);
          ar_credit = v0[`LL_CRED_W-1:0];
          n_lines++;
        end
      end
    end
    $fclose(fd);
    n_a = addr_q.size();
    n_r = flit_q.size();
  endtask

  ////////////////////////////////////////
  // Lane and R channel monitor
  always @(negedge clk_wr) begin
    if (arst_n) begin
      if (tx_phy0[`LL_TX_PUSH_BIT]) begin
        if (push_cnt < n_a) begin
          check_val("tx_phy0", 64'(ar_word(addr_q[push_cnt])), 64'(tx_phy0));
        end else begin
          $display("unexpected address push on tx_phy0 at %0t ns", $time);
          err_cnt++;
        end
        push_cnt++;
      end else begin
        // Without a pushbit only the R credit bit may be set
        idle_word = tx_phy0;
        idle_word[`LL_TX_CRED_BIT] = 1'b0;
        check_val("tx_phy0", 64'd0, 64'(idle_word));
      end
      if (tx_phy0[`LL_TX_CRED_BIT]) begin
        rcred_cnt++;
      end
      if (user_rvalid && user_rready) begin
        if (pop_cnt < n_r) begin
          exp_flit = flit_q[pop_cnt];
          check_val("user_rdata", 64'(exp_flit[`LL_DATA_W-1:0]), 64'(user_rdata));
          check_val("user_rresp", 64'(exp_flit[`LL_R_W-1:`LL_DATA_W]), 64'(user_rresp));
        end else begin
          $display("unexpected R beat on user_rdata at %0t ns", $time);
          err_cnt++;
        end
        pop_cnt++;
      end
    end
  end

  ////////////////////////////////////////
  // Test sequence
  task run_tests();
    test_start = err_cnt;
    repeat (8) @(posedge clk_wr);
    arst_n <= 1'b1;
    @(negedge clk_wr);
    check_val("user_arready", 64'd1, 64'(user_arready));
    check_val("user_rvalid", 64'd0, 64'(user_rvalid));
    check_val("tx_phy0", 64'd0, 64'(tx_phy0));
    end_test("reset state");

    // First address parks in the buffer while offline
    test_start = err_cnt;
    send_addr(addr_q[0]);
    repeat (20) @(negedge clk_wr);
    check_val("tx pushes while offline", 64'd0, 64'(push_cnt));
    check_val("user_arready", 64'd0, 64'(user_arready));
    end_test("offline hold");

    test_start = err_cnt;
    fork
      begin
        for (int i = 1; i < n_a; i++) begin
          repeat (take_bits(2)) @(posedge clk_wr);
          send_addr(addr_q[i]);
        end
        ar_done = 1'b1;
      end
    join_none
    @(posedge clk_wr);
    tx_online <= 1'b1;
    wait (push_cnt == int'(ar_credit));
    repeat (30) @(negedge clk_wr);
    check_val("tx pushes at zero credit", 64'(ar_credit), 64'(push_cnt));
    check_val("user_arready", 64'd0, 64'(user_arready));
    end_test("credit limit");

    // One credit bit per remaining address
    test_start = err_cnt;
    for (k = int'(ar_credit); k < n_a; k++) begin
      @(posedge clk_wr);
      rx_phy0 <= ar_cred_word();
      @(posedge clk_wr);
      rx_phy0 <= '0;
      wait (push_cnt == k + 1);
      repeat (10) @(negedge clk_wr);
      check_val("tx pushes per credit", 64'(k + 1), 64'(push_cnt));
    end
    wait (ar_done);
    end_test("address order");

    test_start = err_cnt;
    @(posedge clk_wr);
    rx_online <= 1'b1;
    repeat (int'(delay_x_value) + 4) @(posedge clk_wr);
    sent = 0;
    // Far side holds 8 R credits
    while (pop_cnt < n_r) begin
      @(posedge clk_wr);
      user_rready <= next_bit();
      if (sent < n_r && (sent - rcred_cnt) < `LL_RX_DEPTH && next_bit()) begin
        rx_phy0 <= r_word(flit_q[sent]);
        sent++;
      end else begin
        rx_phy0 <= '0;
      end
    end
    @(posedge clk_wr);
    rx_phy0     <= '0;
    user_rready <= 1'b0;
    end_test("response order");

    test_start = err_cnt;
    wait (rcred_cnt == pop_cnt);
    repeat (10) @(negedge clk_wr);
    check_val("R credits returned", 64'(pop_cnt), 64'(rcred_cnt));
    end_test("credit return");
  endtask

  task finish_run();
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  // Watchdog of 200 cycles per data line
  initial begin
    wait (loaded);
    repeat (200 * n_lines) @(posedge clk_wr);
    $display("the run timed out after %0d cycles", 200 * n_lines);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    clk_wr         = 1'b0;
    arst_n         = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    init_ar_credit = '0;
    delay_x_value  = 16'd3;
    delay_y_value  = 16'd4;
    user_araddr    = '0;
    user_arvalid   = 1'b0;
    user_rready    = 1'b0;
    rx_phy0        = '0;
    lfsr_state     = 16'd50;
    ar_credit      = '0;
    loaded         = 1'b0;
    ar_done        = 1'b0;
    n_lines        = 0;
    push_cnt       = 0;
    rcred_cnt      = 0;
    pop_cnt        = 0;
    err_cnt        = 0;
    chk_cnt        = 0;
    read_testdata();
    init_ar_credit = ar_credit;
    loaded         = 1'b1;
    if (n_a == 0 || n_r == 0) begin
      $display("test data is missing or has no A or R lines");
      err_cnt++;
    end else begin
      run_tests();
    end
    finish_run();
  end

endmodule

`default_nettype wire

// ==== tb/testdata_rd.txt ====
# A <araddr hex>: read address, expected on tx_phy0 in this order
# R <rresp hex> <rdata hex>: R flit sent on rx_phy0, expected on user_rresp and user_rdata
# C <credit hex>: AR credits granted by the far side
C 02
A 00001000
A 00001004
A 0000200c
A 80000010
A 7ffffffc
A deadbee0
R 0 11111111
R 1 22222222
R 2 33333333
R 3 44444444
R 0 a5a5a5a5
R 0 5a5a5a5a
R 1 0000ffff
R 2 ffff0000
R 0 12345678
R 3 87654321
R 0 cafef00d
